// File: src/mips_isa_pkg.sv
package mips_isa_pkg;

   // primary opcodes
   localparam logic [5:0] OP_RTYPE = 6'h00;
   localparam logic [5:0] OP_J     = 6'h02;
   localparam logic [5:0] OP_BEQ   = 6'h04;
   localparam logic [5:0] OP_BNE   = 6'h05;
   localparam logic [5:0] OP_ADDIU = 6'h09;
   localparam logic [5:0] OP_ORI   = 6'h0d;
   localparam logic [5:0] OP_LUI   = 6'h0f;
   localparam logic [5:0] OP_LB    = 6'h20;
   localparam logic [5:0] OP_LW    = 6'h23;
   localparam logic [5:0] OP_LBU   = 6'h24;
   localparam logic [5:0] OP_SB    = 6'h28;
   localparam logic [5:0] OP_SW    = 6'h2b;

   // funct field of r-type
   localparam logic [5:0] FN_SLL  = 6'h00;
   localparam logic [5:0] FN_ADDU = 6'h21;
   localparam logic [5:0] FN_SUBU = 6'h23;
   localparam logic [5:0] FN_AND  = 6'h24;
   localparam logic [5:0] FN_OR   = 6'h25;
   localparam logic [5:0] FN_XOR  = 6'h26;
   localparam logic [5:0] FN_SLT  = 6'h2a;

   typedef struct packed {
      logic [4:0] rs;      // bits 25:21
      logic [4:0] rt;      // bits 20:16
      logic [4:0] rd;      // bits 15:11
      logic [4:0] shamt;   // bits 10:6
      logic [5:0] funct;   // bits 5:0
   } r_fields_t;

   typedef struct packed {
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm16;  // bits 15:0
   } i_fields_t;

   typedef union packed {
      r_fields_t   r;
      i_fields_t   i;
      logic [25:0] target26; // j-type
   } instr_body_u;

   typedef struct packed {
      logic [5:0]  opcode; // bits 31:26
      instr_body_u body;
   } instr_fields_t;

   localparam instr_fields_t INSTR_NOP = '0; // sll r0,r0,0

endpackage

// File: src/core_ctrl_pkg.sv
package core_ctrl_pkg;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_SLL,
      ALU_PASS_B   // lui
   } alu_op_t;

   typedef enum logic {
      SRC_A_REG,
      SRC_A_SHAMT
   } src_a_t;

   typedef enum logic [1:0] {
      SRC_B_REG,
      SRC_B_SIMM,  // sign extended imm16
      SRC_B_ZIMM,  // zero extended imm16
      SRC_B_UIMM   // imm16 in upper half
   } src_b_t;

   typedef enum logic {
      FWD_RF,
      FWD_MW
   } fwd_t;

   typedef enum logic {
      ACC_BYTE,
      ACC_WORD
   } acc_size_t;

   typedef struct packed {
      alu_op_t   alu_op;
      src_a_t    src_a;
      src_b_t    src_b;
      logic      reg_write;
      logic [4:0] dest;
      logic      mem_read;
      logic      mem_write;
      acc_size_t acc_size;
      logic      load_signed;
      logic      branch_eq;
      logic      branch_ne;
      logic      jump;
   } ctrl_t;

   localparam ctrl_t CTRL_NOP = '{
      alu_op: ALU_ADD, src_a: SRC_A_REG, src_b: SRC_B_REG,
      reg_write: 1'b0, dest: 5'd0,
      mem_read: 1'b0, mem_write: 1'b0, acc_size: ACC_WORD, load_signed: 1'b0,
      branch_eq: 1'b0, branch_ne: 1'b0, jump: 1'b0
   };

endpackage

// File: src/mem_req_if.sv
`timescale 1ns/1ps

interface mem_req_if import core_ctrl_pkg::*; ();

   logic        req;         // access sitting in mem/wb
   logic        we;
   logic [31:0] addr;
   logic [31:0] wdata;       // store data, not yet on lanes
   acc_size_t   size;
   logic        load_signed;
   logic        done;        // one cycle pulse
   logic [31:0] rdata;       // aligned and extended

   modport dp (
      output req, we, addr, wdata, size, load_signed,
      input  done, rdata
   );

   modport lsu (
      input  req, we, addr, wdata, size, load_signed,
      output done, rdata
   );

endinterface

// File: src/core_alu.sv
`timescale 1ns/1ps

module core_alu import core_ctrl_pkg::*; (
   input  logic [31:0] a,
   input  logic [31:0] b,
   input  alu_op_t     op,
   output logic [31:0] y
);

   logic        a_lt_b;

   assign a_lt_b = ($signed(a) < $signed(b));

   always_comb begin
      case (op)
         ALU_ADD:    y = a + b;            // wraps, no overflow trap
         ALU_SUB:    y = a - b;
         ALU_AND:    y = a & b;
         ALU_OR:     y = a | b;
         ALU_XOR:    y = a ^ b;
         ALU_SLT:    y = {31'd0, a_lt_b};
         ALU_SLL:    y = b << a[4:0];      // shift amount on a
         ALU_PASS_B: y = b;
         default:    y = b;
      endcase
   end

endmodule

// File: src/core_regfile.sv
`timescale 1ns/1ps

module core_regfile (
   input  logic        CLK,
   input  logic [4:0]  ra1,
   input  logic [4:0]  ra2,
   output logic [31:0] rd1,
   output logic [31:0] rd2,
   input  logic        we,
   input  logic [4:0]  wa,
   input  logic [31:0] wd
);

   logic [31:0] regs [32];

   always_ff @(posedge CLK) begin
      if (we)
         regs[wa] <= wd;
   end

   // same-cycle write shows up next cycle, forwarding covers the gap
   assign rd1 = (ra1 == 5'd0) ? 32'd0 : regs[ra1];
   assign rd2 = (ra2 == 5'd0) ? 32'd0 : regs[ra2];

endmodule

// File: src/core_control.sv
`timescale 1ns/1ps

module core_control import mips_isa_pkg::*, core_ctrl_pkg::*; (
   input  instr_fields_t ex_instr,
   input  logic [4:0]    mw_dest,
   input  logic          mw_reg_write,
   output ctrl_t         ctrl,
   output fwd_t          fwd_a,
   output fwd_t          fwd_b
);

   ctrl_t c;
   logic  mw_hot;

   always_comb begin
      c = CTRL_NOP;
      case (ex_instr.opcode)
         OP_RTYPE: begin
            c.dest      = ex_instr.body.r.rd;
            c.reg_write = 1'b1;
            case (ex_instr.body.r.funct)
               FN_ADDU: c.alu_op = ALU_ADD;
               FN_SUBU: c.alu_op = ALU_SUB;
               FN_AND:  c.alu_op = ALU_AND;
               FN_OR:   c.alu_op = ALU_OR;
               FN_XOR:  c.alu_op = ALU_XOR;
               FN_SLT:  c.alu_op = ALU_SLT;
               FN_SLL: begin
                  c.alu_op = ALU_SLL;
                  c.src_a  = SRC_A_SHAMT; // rt << shamt
               end
               default: c.reg_write = 1'b0;
            endcase
         end
         OP_ADDIU: begin
            c.src_b = SRC_B_SIMM;
            c.dest = ex_instr.body.i.rt;
            c.reg_write = 1'b1;
         end
         OP_ORI: begin
            c.alu_op = ALU_OR;
            c.src_b = SRC_B_ZIMM;
            c.dest = ex_instr.body.i.rt;
            c.reg_write = 1'b1;
         end
         OP_LUI: begin
            c.alu_op = ALU_PASS_B;
            c.src_b = SRC_B_UIMM;
            c.dest = ex_instr.body.i.rt;
            c.reg_write = 1'b1;
         end
         OP_LW, OP_LB, OP_LBU: begin
            c.src_b = SRC_B_SIMM; // base + offset
            c.dest = ex_instr.body.i.rt;
            c.reg_write = 1'b1;
            c.mem_read = 1'b1;
            c.acc_size = (ex_instr.opcode == OP_LW) ? ACC_WORD : ACC_BYTE;
            c.load_signed = (ex_instr.opcode == OP_LB);
         end
         OP_SW, OP_SB: begin
            c.src_b = SRC_B_SIMM;
            c.mem_write = 1'b1;
            c.acc_size = (ex_instr.opcode == OP_SW) ? ACC_WORD : ACC_BYTE;
         end
         OP_BEQ:  c.branch_eq = 1'b1;
         OP_BNE:  c.branch_ne = 1'b1;
         OP_J:    c.jump = 1'b1;
         default: c = CTRL_NOP;
      endcase
      if (c.dest == 5'd0)
         c.reg_write = 1'b0;      // r0 writes are dropped here
   end

   assign ctrl = c;

   // mem/wb result overrides a stale regfile read
   assign mw_hot = mw_reg_write & (mw_dest != 5'd0);
   assign fwd_a  = (mw_hot && mw_dest == ex_instr.body.r.rs) ? FWD_MW : FWD_RF;
   assign fwd_b  = (mw_hot && mw_dest == ex_instr.body.r.rt) ? FWD_MW : FWD_RF;

endmodule

// File: src/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit import core_ctrl_pkg::*; (
   input  logic        CLK,
   input  logic        arst_n,
   mem_req_if.lsu      mem,
   output logic        wb_cyc,
   output logic        wb_stb,
   output logic        wb_we,
   output logic [31:0] wb_adr,
   output logic [3:0]  wb_sel,
   output logic [31:0] wb_dat_o,
   input  logic [31:0] wb_dat_i,
   input  logic        wb_ack
);

   typedef enum logic {
      ST_IDLE,
      ST_BUSY
   } lsu_state_t;

   lsu_state_t  state;
   logic [1:0]  offset;
   logic [7:0]  lane;

   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE: if (mem.req) state <= ST_BUSY;
            ST_BUSY: if (wb_ack) state <= ST_IDLE; // cyc drops after ack
            default: state <= ST_IDLE;
         endcase
      end
   end

   assign wb_cyc = (state == ST_BUSY);
   assign wb_stb = (state == ST_BUSY);
   assign wb_we  = mem.we;
   assign wb_adr = {mem.addr[31:2], 2'b00};
   assign offset = mem.addr[1:0];

   // big endian, offset 0 is bits 31:24
   always_comb begin
      if (mem.size == ACC_BYTE) begin
         wb_sel   = 4'b1000 >> offset;
         wb_dat_o = {4{mem.wdata[7:0]}}; // same byte on every lane
      end else begin
         wb_sel   = 4'b1111;
         wb_dat_o = mem.wdata;
      end
   end

   always_comb begin
      case (offset)
         2'd0:    lane = wb_dat_i[31:24];
         2'd1:    lane = wb_dat_i[23:16];
         2'd2:    lane = wb_dat_i[15:8];
         default: lane = wb_dat_i[7:0];
      endcase
   end

   assign mem.rdata = (mem.size == ACC_BYTE) ?
                      {{24{mem.load_signed & lane[7]}}, lane} : wb_dat_i;
   assign mem.done  = wb_cyc & wb_ack;

endmodule

// File: src/core_datapath.sv
`timescale 1ns/1ps

module core_datapath import mips_isa_pkg::*, core_ctrl_pkg::*; #(
   parameter logic [31:0] RESET_PC = 32'h0
) (
   input  logic          CLK,
   input  logic          arst_n,
   output logic [31:0]   imem_addr,
   input  logic [31:0]   imem_rdata,
   output instr_fields_t ex_instr,
   input  ctrl_t         ctrl,
   input  fwd_t          fwd_a,
   input  fwd_t          fwd_b,
   output logic [4:0]    mw_dest,
   output logic          mw_reg_write,
   output logic [4:0]    rf_ra1,
   output logic [4:0]    rf_ra2,
   input  logic [31:0]   rf_rd1,
   input  logic [31:0]   rf_rd2,
   output logic          rf_we,
   output logic [4:0]    rf_wa,
   output logic [31:0]   rf_wd,
   output logic [31:0]   alu_a,
   output logic [31:0]   alu_b,
   output alu_op_t       alu_op,
   input  logic [31:0]   alu_y,
   mem_req_if.dp         mem
);

   logic [31:0] pc, pc_next;
   logic [31:0] ex_pc, ex_pc4;
   logic        ex_valid;          // low for the bubble after reset
   logic [31:0] if_word;
   logic [31:0] if_hold;           // fetched word kept while stalled
   logic        if_held;
   logic [31:0] op_a, op_b;
   logic [31:0] simm;
   logic [31:0] br_target, j_target;
   logic        ops_equal, br_taken;
   logic        stall;

   logic [31:0] mw_alu;
   logic [31:0] mw_wdata;
   logic        mw_mem_read, mw_mem_write;
   acc_size_t   mw_size;
   logic        mw_load_signed;

   assign stall     = mem.req & ~mem.done;
   assign imem_addr = pc;

   // instruction word arrives one cycle after its pc
   assign if_word  = if_held ? if_hold : imem_rdata;
   assign ex_instr = ex_valid ? instr_fields_t'(if_word) : INSTR_NOP;
   assign rf_ra1   = ex_instr.body.r.rs;
   assign rf_ra2   = ex_instr.body.r.rt;

   assign op_a = (fwd_a == FWD_MW) ? rf_wd : rf_rd1;
   assign op_b = (fwd_b == FWD_MW) ? rf_wd : rf_rd2;
   assign simm = {{16{ex_instr.body.i.imm16[15]}}, ex_instr.body.i.imm16};

   assign alu_a  = (ctrl.src_a == SRC_A_SHAMT) ? {27'd0, ex_instr.body.r.shamt} : op_a;
   assign alu_op = ctrl.alu_op;

   always_comb begin
      case (ctrl.src_b)
         SRC_B_SIMM: alu_b = simm;
         SRC_B_ZIMM: alu_b = {16'd0, ex_instr.body.i.imm16};
         SRC_B_UIMM: alu_b = {ex_instr.body.i.imm16, 16'd0};
         default:    alu_b = op_b;
      endcase
   end

   // control flow resolves here, the delay slot is already on imem
   assign ops_equal = (op_a == op_b);
   assign br_taken  = (ctrl.branch_eq & ops_equal) | (ctrl.branch_ne & ~ops_equal);
   assign ex_pc4    = ex_pc + 32'd4;
   assign br_target = ex_pc4 + {simm[29:0], 2'b00};
   assign j_target  = {ex_pc4[31:28], ex_instr.body.target26, 2'b00};

   always_comb begin
      if (ctrl.jump)
         pc_next = j_target;
      else if (br_taken)
         pc_next = br_target;
      else
         pc_next = pc + 32'd4;
   end

   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         pc           <= RESET_PC;
         ex_valid     <= 1'b0;
         mw_reg_write <= 1'b0;
         mw_mem_read  <= 1'b0;
         mw_mem_write <= 1'b0;
      end else if (!stall) begin
         pc           <= pc_next;
         ex_valid     <= 1'b1;
         mw_reg_write <= ctrl.reg_write;
         mw_mem_read  <= ctrl.mem_read;
         mw_mem_write <= ctrl.mem_write;
      end
   end

   // imem keeps reading the frozen pc, so the word in execute is saved
   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n)
         if_held <= 1'b0;
      else
         if_held <= stall;
   end

   always_ff @(posedge CLK) begin
      if (stall && !if_held)
         if_hold <= imem_rdata;
   end

   always_ff @(posedge CLK) begin
      if (!stall) begin
         ex_pc          <= pc;
         mw_alu         <= alu_y;   // also the access address
         mw_wdata       <= op_b;    // rt for stores
         mw_dest        <= ctrl.dest;
         mw_size        <= ctrl.acc_size;
         mw_load_signed <= ctrl.load_signed;
      end
   end

   assign mem.req         = mw_mem_read | mw_mem_write;
   assign mem.we          = mw_mem_write;
   assign mem.addr        = mw_alu;
   assign mem.wdata       = mw_wdata;
   assign mem.size        = mw_size;
   assign mem.load_signed = mw_load_signed;

   // write back, loads retire in the done cycle
   assign rf_we = mw_reg_write & ~stall;
   assign rf_wa = mw_dest;
   assign rf_wd = mw_mem_read ? mem.rdata : mw_alu;

endmodule

// File: src/mips_core_top.sv
`timescale 1ns/1ps

module mips_core_top import mips_isa_pkg::*, core_ctrl_pkg::*; #(
   parameter logic [31:0] RESET_PC = 32'h0
) (
   input  logic        CLK,
   input  logic        arst_n,
   output logic [31:0] imem_addr,
   input  logic [31:0] imem_rdata,
   output logic        wb_cyc,
   output logic        wb_stb,
   output logic        wb_we,
   output logic [31:0] wb_adr,
   output logic [3:0]  wb_sel,
   output logic [31:0] wb_dat_o,
   input  logic [31:0] wb_dat_i,
   input  logic        wb_ack,
   output logic        ret_valid,
   output logic [4:0]  ret_reg,
   output logic [31:0] ret_data
);

   instr_fields_t ex_instr;
   ctrl_t         ctrl;
   fwd_t          fwd_a, fwd_b;
   logic [4:0]    mw_dest;
   logic          mw_reg_write;
   logic [4:0]    rf_ra1, rf_ra2;
   logic [31:0]   rf_rd1, rf_rd2;
   logic [31:0]   alu_a, alu_b, alu_y;
   alu_op_t       alu_op;

   mem_req_if i_mem ();

   core_datapath #(.RESET_PC(RESET_PC)) i_datapath (
      .CLK, .arst_n, .imem_addr, .imem_rdata,
      .ex_instr, .ctrl, .fwd_a, .fwd_b, .mw_dest, .mw_reg_write,
      .rf_ra1, .rf_ra2, .rf_rd1, .rf_rd2,
      .rf_we(ret_valid), .rf_wa(ret_reg), .rf_wd(ret_data), // retire = rf write
      .alu_a, .alu_b, .alu_op, .alu_y,
      .mem(i_mem.dp)
   );

   core_control i_control (.ex_instr, .mw_dest, .mw_reg_write, .ctrl, .fwd_a, .fwd_b);

   core_regfile i_regfile (
      .CLK, .ra1(rf_ra1), .ra2(rf_ra2), .rd1(rf_rd1), .rd2(rf_rd2),
      .we(ret_valid), .wa(ret_reg), .wd(ret_data)
   );

   core_alu i_alu (.a(alu_a), .b(alu_b), .op(alu_op), .y(alu_y));

   load_store_unit i_lsu (
      .CLK, .arst_n, .mem(i_mem.lsu),
      .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_sel, .wb_dat_o, .wb_dat_i, .wb_ack
   );

endmodule

// File: bench/mips_core_assertions.sv
`timescale 1ns/1ps

module mips_core_assertions (
   input logic        CLK,
   input logic        arst_n,
   input logic        wb_cyc,
   input logic        wb_stb,
   input logic        wb_we,
   input logic [31:0] wb_adr,
   input logic [3:0]  wb_sel,
   input logic [31:0] wb_dat_o,
   input logic        wb_ack,
   input logic        ret_valid,
   input logic [4:0]  ret_reg
);

   stb_in_cyc: assert property (@(posedge CLK) disable iff (!arst_n) wb_stb |-> wb_cyc)
      else $error("wb_stb high outside a cycle");

   // request held steady until the slave answers
   req_stable: assert property (@(posedge CLK) disable iff (!arst_n)
      wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_sel) && $stable(wb_we)
                            && $stable(wb_dat_o))
      else $error("wishbone request changed before ack");

   ack_needs_stb: assert property (@(posedge CLK) disable iff (!arst_n) wb_ack |-> wb_stb)
      else $error("wb_ack without wb_stb");

   ret_not_r0: assert property (@(posedge CLK) disable iff (!arst_n)
      ret_valid |-> ret_reg != 5'd0)
      else $error("retire to register 0");

endmodule

bind mips_core_top mips_core_assertions i_assertions (.*);

// File: bench/mips_core_tb.sv
`timescale 1ns/1ps

module mips_core_tb import mips_isa_pkg::*; ();

   localparam logic [31:0] RESET_PC = 32'h0;
   localparam int SEED_LEN = 14;                  // lui/ori pairs for r1..r7
   localparam int BODY_LEN = 40;
   localparam int PROG_LEN = SEED_LEN + BODY_LEN + 8; // 8 nop pad
   localparam int NUM_TESTS = 4;

   typedef struct packed {
      logic        valid;
      logic        is_store;
      logic [31:0] addr;   // word address, or register number on retire
      logic [3:0]  sel;
      logic [31:0] data;
   } event_t;

   logic        CLK = 1'b0;
   logic        arst_n;
   logic [31:0] imem_addr, imem_rdata;
   logic        wb_cyc, wb_stb, wb_we, wb_ack;
   logic [31:0] wb_adr, wb_dat_o, wb_dat_i;
   logic [3:0]  wb_sel;
   logic        ret_valid;
   logic [4:0]  ret_reg;
   logic [31:0] ret_data;

   logic [31:0] imem [256];
   logic [31:0] dmem [256];
   logic [31:0] m_regs [32];
   logic [31:0] m_mem [256];
   logic [31:0] m_pc, m_npc;
   logic [31:0] rng_state = 32'd31343;
   event_t      exp_q [$];
   int          err_count = 0;
   time         deadline = 64'd1_000_000;
   logic        zero_wait;
   logic        bus_active = 1'b0;
   int          wait_left = 0;
   logic        s_rst, s_cyc, s_ack, s_we;
   logic [31:0] s_adr, s_dat, f_adr;
   logic [3:0]  s_sel;

   mips_core_top #(.RESET_PC(RESET_PC)) i_dut (.*);

   always #5 CLK = ~CLK;

   function automatic logic [31:0] next_random();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic logic [4:0] pick_reg();
      logic [31:0] r;
      r = next_random();
      return 5'(1 + r % 7);
   endfunction

   function automatic logic [31:0] enc_r(logic [4:0] rs, rt, rd, sh, logic [5:0] fn);
      return {OP_RTYPE, rs, rt, rd, sh, fn};
   endfunction

   function automatic logic [31:0] enc_i(logic [5:0] op, logic [4:0] rs, rt, logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic logic [31:0] imem_word(logic [31:0] addr);
      logic [31:0] idx;
      idx = (addr - RESET_PC) >> 2;
      return (idx < 256) ? imem[idx] : 32'h0;  // nop past the array
   endfunction

   function automatic logic [31:0] fill_word(int k);
      return {8'(k), 8'(k) ^ 8'hc3, 8'(k * 7), 8'(k) ^ 8'h5a};
   endfunction

   function automatic logic [31:0] lane_mask(logic [3:0] sel);
      return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
   endfunction

   // one instruction on the model state, delay slot via m_npc
   function automatic event_t ref_step();
      logic [31:0] ins, a, b, simm, res, addr, w, nxt;
      logic [7:0]  byt;
      logic [4:0]  dest;
      logic        wr;
      event_t      ev;
      ev = '0;
      ins = imem_word(m_pc);
      a = m_regs[ins[25:21]];
      b = m_regs[ins[20:16]];
      simm = {{16{ins[15]}}, ins[15:0]};
      addr = a + simm;
      w = m_mem[addr[9:2]];
      byt = 8'(w >> (8 * (3 - int'(addr[1:0])))); // offset 0 is the top byte
      nxt = m_npc + 32'd4;
      dest = ins[20:16];
      wr = 1'b1;
      res = 32'h0;
      case (ins[31:26])
         OP_RTYPE: begin
            dest = ins[15:11];
            case (ins[5:0])
               FN_ADDU: res = a + b;
               FN_SUBU: res = a - b;
               FN_AND:  res = a & b;
               FN_OR:   res = a | b;
               FN_XOR:  res = a ^ b;
               FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
               FN_SLL:  res = b << ins[10:6];
               default: wr = 1'b0;
            endcase
         end
         OP_ADDIU: res = a + simm;
         OP_ORI:   res = a | {16'd0, ins[15:0]};
         OP_LUI:   res = {ins[15:0], 16'd0};
         OP_LW:    res = w;
         OP_LB:    res = {{24{byt[7]}}, byt};
         OP_LBU:   res = {24'd0, byt};
         OP_SW, OP_SB: begin
            wr = 1'b0;
            ev.valid = 1'b1;
            ev.is_store = 1'b1;
            ev.addr = {addr[31:2], 2'b00};
            ev.sel = (ins[31:26] == OP_SW) ? 4'b1111 : (4'b1000 >> addr[1:0]);
            ev.data = (ins[31:26] == OP_SW) ? b : {4{b[7:0]}};
            m_mem[addr[9:2]] = (w & ~lane_mask(ev.sel)) | (ev.data & lane_mask(ev.sel));
         end
         default: begin
            wr = 1'b0;
            if ((ins[31:26] == OP_BEQ && a == b) || (ins[31:26] == OP_BNE && a != b))
               nxt = m_pc + 32'd4 + {simm[29:0], 2'b00};
            else if (ins[31:26] == OP_J)
               nxt = {m_npc[31:28], ins[25:0], 2'b00};
         end
      endcase
      if (wr && dest != 5'd0) begin
         m_regs[dest] = res;
         ev = '{valid: 1'b1, is_store: 1'b0, addr: {27'd0, dest}, sel: 4'h0, data: res};
      end
      m_pc = m_npc;
      m_npc = nxt;
      return ev;
   endfunction

   task automatic build_program();
      logic [31:0] r;
      logic [4:0]  rs, rt, rd;
      logic [15:0] off;
      int          kind;
      logic        prev_ctrl;
      for (int k = 0; k < 256; k++)
         imem[k] = 32'h0;
      for (int k = 1; k <= 7; k++) begin
         r = next_random();
         imem[2*k-2] = enc_i(OP_LUI, 5'd0, 5'(k), r[31:16]);
         imem[2*k-1] = enc_i(OP_ORI, 5'(k), 5'(k), r[15:0]);
      end
      prev_ctrl = 1'b0;
      for (int i = 0; i < BODY_LEN; i++) begin
         r = next_random();
         rs = pick_reg();
         rt = pick_reg();
         rd = pick_reg();
         kind = int'(r[3:0]);
         if (kind == 15 && (prev_ctrl || i == BODY_LEN - 1))
            kind = 0;                                  // no branch in a delay slot
         off = 16'(1 + r[9:8]);                        // forward only
         case (kind)
            0:  imem[SEED_LEN+i] = enc_r(rs, rt, rd, 5'd0, FN_ADDU);
            1:  imem[SEED_LEN+i] = enc_r(rs, rt, rd, 5'd0, FN_SUBU);
            2:  imem[SEED_LEN+i] = enc_r(rs, rt, rd, 5'd0, FN_AND);
            3:  imem[SEED_LEN+i] = enc_r(rs, rt, rd, 5'd0, FN_OR);
            4:  imem[SEED_LEN+i] = enc_r(rs, rt, rd, 5'd0, FN_XOR);
            5:  imem[SEED_LEN+i] = enc_r(rs, rt, rd, 5'd0, FN_SLT);
            6:  imem[SEED_LEN+i] = enc_r(5'd0, rt, rd, r[14:10], FN_SLL);
            7:  imem[SEED_LEN+i] = enc_i(OP_ADDIU, rs, rt, r[31:16]);
            8:  imem[SEED_LEN+i] = enc_i(OP_ORI, rs, rt, r[31:16]);
            9:  imem[SEED_LEN+i] = enc_i(OP_LUI, 5'd0, rt, r[31:16]);
            10: imem[SEED_LEN+i] = enc_i(OP_LW, 5'd0, rt, {6'd0, r[23:16], 2'b00});
            11: imem[SEED_LEN+i] = enc_i(OP_LB, 5'd0, rt, {6'd0, r[25:16]});
            12: imem[SEED_LEN+i] = enc_i(OP_LBU, 5'd0, rt, {6'd0, r[25:16]});
            13: imem[SEED_LEN+i] = enc_i(OP_SW, 5'd0, rt, {6'd0, r[23:16], 2'b00});
            14: imem[SEED_LEN+i] = enc_i(OP_SB, 5'd0, rt, {6'd0, r[25:16]});
            default: begin
               if (r[5:4] == 2'd0)
                  imem[SEED_LEN+i] = enc_i(OP_BEQ, rs, r[6] ? rs : rt, off);
               else if (r[5:4] == 2'd1)
                  imem[SEED_LEN+i] = enc_i(OP_BNE, rs, rt, off);
               else
                  imem[SEED_LEN+i] = {OP_J, 26'(SEED_LEN + i + 1 + int'(off))};
            end
         endcase
         prev_ctrl = (kind == 15);
      end
   endtask

   task automatic build_expected();
      event_t ev;
      exp_q.delete();
      for (int k = 0; k < 32; k++)
         m_regs[k] = 32'h0;
      for (int k = 0; k < 256; k++) begin
         m_mem[k] = fill_word(k);
         dmem[k] = fill_word(k);
      end
      m_pc = RESET_PC;
      m_npc = RESET_PC + 32'd4;
      while (m_pc < RESET_PC + 32'(4 * PROG_LEN)) begin
         ev = ref_step();
         if (ev.valid)
            exp_q.push_back(ev);
      end
   endtask

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         err_count++;
         $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
         $display("TESTS FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic check_event(input logic is_store, input logic [31:0] a, input logic [3:0] sel,
                              input logic [31:0] d);
      event_t e;
      if (exp_q.size() == 0) begin
         $display("At %0t the core produced a %s that the model did not predict",
                  $time, is_store ? "store" : "register write");
         $display("TESTS FAILED");
         $fatal(1, "extra event");
      end
      e = exp_q.pop_front();
      check_value("event is_store", {31'd0, is_store}, {31'd0, e.is_store});
      if (is_store) begin
         check_value("wb_adr", a, e.addr);
         check_value("wb_sel", {28'd0, sel}, {28'd0, e.sel});
         check_value("wb_dat_o", d, e.data);
      end else begin
         check_value("ret_reg", a, e.addr);
         check_value("ret_data", d, e.data);
      end
   endtask

   // fetch port, one cycle of read latency
   always @(posedge CLK) begin
      f_adr = imem_addr;
      #1;
      imem_rdata = imem_word(f_adr);
   end

   // wishbone slave, 0 to 3 wait states
   always @(posedge CLK) begin
      s_rst = !arst_n;
      s_cyc = wb_cyc & wb_stb;
      s_ack = wb_ack;
      s_we = wb_we;
      s_adr = wb_adr;
      s_sel = wb_sel;
      s_dat = wb_dat_o;
      #1;
      if (s_rst) begin
         wb_ack = 1'b0;
         bus_active = 1'b0;
      end else if (s_cyc && s_ack) begin
         if (s_we)
            dmem[s_adr[9:2]] = (dmem[s_adr[9:2]] & ~lane_mask(s_sel)) | (s_dat & lane_mask(s_sel));
         wb_ack = 1'b0;
         bus_active = 1'b0;
      end else if (s_cyc) begin
         if (!bus_active) begin
            bus_active = 1'b1;
            wait_left = zero_wait ? 0 : int'(next_random() % 4);
         end
         if (wait_left == 0) begin
            wb_ack = 1'b1;
            wb_dat_i = dmem[s_adr[9:2]];
         end else begin
            wait_left--;
         end
      end
   end

   always @(posedge CLK) begin
      if (arst_n) begin
         if (ret_valid)
            check_event(1'b0, {27'd0, ret_reg}, 4'h0, ret_data);
         if (wb_cyc && wb_stb && wb_we && wb_ack)
            check_event(1'b1, wb_adr, wb_sel, wb_dat_o);
      end
   end

   always @(posedge CLK) begin
      if ($time > deadline) begin
         $display("Timeout: %0d expected events never arrived", exp_q.size());
         $display("TESTS FAILED");
         $fatal(1, "watchdog expired");
      end
   end

   initial begin
      arst_n = 1'b0;
      imem_rdata = 32'h0;
      wb_dat_i = 32'h0;
      wb_ack = 1'b0;
      zero_wait = 1'b1;
      for (int t = 0; t < NUM_TESTS; t++) begin
         @(posedge CLK);
         #1 arst_n = 1'b0;                 // stop the core before reloading memory
         zero_wait = (t % 2 == 0);         // each program runs zero-wait, then with waits
         if (zero_wait)
            build_program();
         build_expected();
         deadline = $time + 64'(10 * (20 * exp_q.size() + 100));
         repeat (2) @(posedge CLK);
         #1;
         check_value("imem_addr", imem_addr, RESET_PC);
         check_value("wb_cyc", {31'd0, wb_cyc}, 32'd0);
         check_value("ret_valid", {31'd0, ret_valid}, 32'd0);
         arst_n = 1'b1;
         while (exp_q.size() != 0)
            @(posedge CLK);
         repeat (10) @(posedge CLK);       // catch duplicates
      end
      if (err_count == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

// File: mips_core.f
src/mips_isa_pkg.sv
src/core_ctrl_pkg.sv
src/mem_req_if.sv
src/core_alu.sv
src/core_regfile.sv
src/core_control.sv
src/load_store_unit.sv
src/core_datapath.sv
src/mips_core_top.sv
bench/mips_core_assertions.sv
bench/mips_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and grep the log for the verdict
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f mips_core.f \
   --top-module mips_core_tb -o Vmips_core_tb \
   && ./obj_dir/Vmips_core_tb > sim.log 2>&1 \
   || echo "build or simulation ended with an error"

cat sim.log 2>/dev/null
grep -q "^TESTS PASSED$" sim.log 2>/dev/null && exit 0 || exit 1
